/* event_counter_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module event_counter_bank
    import perf_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input trace_events_t captured,
    input counter_cfg_t cfg,
    output counter_t [num_counters-1:0] counts,
    output logic [num_counters-1:0] wrap
);

    logic [ev_completing-1:0] single_events;
    counter_t [num_counters-1:0] increment;
    counter_t [num_counters-1:0] sum;
    logic [num_counters-1:0] carry;

    // Per-counter increment for the selected event
    function automatic counter_t event_increment(
        input event_sel_t sel,
        input logic [ev_completing-1:0] bits,
        input completing_t completing
    );
        counter_t inc;
        inc = '0;
        if (sel < ev_completing) begin
            inc = counter_t'(bits[sel]);
        end else if (sel == ev_completing) begin
            inc = counter_t'(completing);
        end
        // Anything past the last event adds nothing
        return inc;
    endfunction

    //////////////////////////////
    // Single-bit events by index
    always_comb begin
        single_events[ev_operand_stall] = captured.operand_stall;
        single_events[ev_unit_stall] = captured.unit_stall;
        single_events[ev_no_id_stall] = captured.no_id_stall;
        single_events[ev_no_instruction_stall] = captured.no_instruction_stall;
        single_events[ev_other_stall] = captured.other_stall;
        single_events[ev_instruction_issued] = captured.instruction_issued;
        single_events[ev_alu_op] = captured.alu_op;
        single_events[ev_branch_or_jump_op] = captured.branch_or_jump_op;
        single_events[ev_load_op] = captured.load_op;
        single_events[ev_store_op] = captured.store_op;
        single_events[ev_mul_op] = captured.mul_op;
        single_events[ev_div_op] = captured.div_op;
        single_events[ev_misc_op] = captured.misc_op;
        single_events[ev_branch_correct] = captured.branch_correct;
        single_events[ev_branch_misspredict] = captured.branch_misspredict;
        single_events[ev_return_correct] = captured.return_correct;
        single_events[ev_return_misspredict] = captured.return_misspredict;
        single_events[ev_early_branch_correction] = captured.early_branch_correction;
    end

    //////////////////////////////
    // Counters
    always_comb begin
        for (int i = 0; i < num_counters; i++) begin
            increment[i] = event_increment(cfg.sel[i], single_events,
                                           captured.num_instructions_completing);
            {carry[i], sum[i]} = {1'b0, counts[i]} + {1'b0, increment[i]};
        end
    end

    // Clear beats load, load beats counting
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < num_counters; i++) begin
                if (cfg.clear) begin
                    counts[i] <= '0;
                end else if (cfg.load[i]) begin
                    counts[i] <= cfg.load_value;
                end else if (cfg.enable) begin
                    counts[i] <= sum[i];
                end
            end
        end
    end

    // Wrap only when the increment is actually applied
    always_comb begin
        for (int i = 0; i < num_counters; i++) begin
            wrap[i] = cfg.enable & ~cfg.clear & ~cfg.load[i] & carry[i];
        end
    end

endmodule

`default_nettype wire

/* perf_csr_apb.sv */
`timescale 1ns/100ps
`default_nettype none

module perf_csr_apb
    import perf_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input counter_t [num_counters-1:0] counts,
    input logic [num_counters-1:0] wrap,
    output counter_cfg_t cfg
);

    logic access;
    logic wr;
    logic mapped;
    logic hit_ctrl;
    logic hit_status;
    logic [num_counters-1:0] hit_sel;
    logic [num_counters-1:0] hit_count;
    logic [num_counters-1:0] wrap_clr;
    logic [num_counters-1:0] wrap_status;
    logic enable_q;
    event_sel_t [num_counters-1:0] sel_q;
    apb_data_t rdata;

    //////////////////////////////
    // Address decode
    assign access = apb_req.psel & apb_req.penable;

    assign hit_ctrl = (apb_req.paddr == addr_ctrl);
    assign hit_status = (apb_req.paddr == addr_status);

    always_comb begin
        hit_sel = '0;
        hit_count = '0;
        for (int i = 0; i < num_counters; i++) begin
            hit_sel[i] = (apb_req.paddr == apb_addr_t'(addr_sel_base + i * addr_stride));
            hit_count[i] = (apb_req.paddr == apb_addr_t'(addr_count_base + i * addr_stride));
        end
    end

    assign mapped = hit_ctrl | hit_status | (|hit_sel) | (|hit_count);

    // Unmapped writes are dropped along with the error
    assign wr = access & apb_req.pwrite & mapped;

    //////////////////////////////
    // Control and select registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
            sel_q <= '0;
        end else if (wr) begin
            if (hit_ctrl) begin
                enable_q <= apb_req.pwdata[ctrl_enable_bit];
            end
            for (int i = 0; i < num_counters; i++) begin
                if (hit_sel[i]) begin
                    sel_q[i] <= event_sel_t'(apb_req.pwdata);
                end
            end
        end
    end

    //////////////////////////////
    // Sticky wrap status

    // Write one to clear, a new wrap in the same cycle wins
    assign wrap_clr = (wr && hit_status) ? apb_req.pwdata[num_counters-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrap_status <= '0;
        end else begin
            wrap_status <= (wrap_status & ~wrap_clr) | wrap;
        end
    end

    //////////////////////////////
    // Counter bank steering

    // Clear and load act at the edge ending the access cycle
    always_comb begin
        cfg.enable = enable_q;
        cfg.clear = wr & hit_ctrl & apb_req.pwdata[ctrl_clear_bit];
        cfg.load = wr ? hit_count : '0;
        cfg.load_value = apb_req.pwdata;
        cfg.sel = sel_q;
    end

    //////////////////////////////
    // Read path
    always_comb begin
        rdata = '0;
        // Clear is a pulse and reads back as zero
        if (hit_ctrl) begin
            rdata[ctrl_enable_bit] = enable_q;
        end
        if (hit_status) begin
            rdata[num_counters-1:0] = wrap_status;
        end
        for (int i = 0; i < num_counters; i++) begin
            if (hit_sel[i]) begin
                rdata = apb_data_t'(sel_q[i]);
            end
            if (hit_count[i]) begin
                rdata = counts[i];
            end
        end
    end

    // No wait states
    always_comb begin
        apb_rsp.pready = access;
        apb_rsp.pslverr = access & ~mapped;
        apb_rsp.prdata = (access & ~apb_req.pwrite) ? rdata : '0;
    end

endmodule

`default_nettype wire

/* perf_monitor_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module perf_monitor_checker
    import perf_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input trace_events_t raw_events,
    input trace_events_t tr,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input counter_cfg_t cfg
);

    // Failed assertions so far, read by the testbench
    int fail_count = 0;

    logic access;

    assign access = apb_req.psel & apb_req.penable;

    // Register map as listed for the APB block
    function automatic logic addr_mapped(input apb_addr_t addr);
        logic hit;
        hit = (addr == addr_ctrl) || (addr == addr_status);
        for (int i = 0; i < num_counters; i++) begin
            hit = hit || (addr == apb_addr_t'(addr_sel_base + 4 * i));
            hit = hit || (addr == apb_addr_t'(addr_count_base + 4 * i));
        end
        return hit;
    endfunction

    //////////////////////////////
    // Trace path

    // One cycle of latency from raw events to tr
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> tr == $past(raw_events))
    else begin
        fail_count++;
        $error("tr does not match raw_events of the previous cycle");
    end

    // Reset state right after release
    assert property (@(posedge clk) disable iff (!rst_n)
        !$past(rst_n) |-> (tr == '0) && !cfg.enable && (cfg.sel == '0))
    else begin
        fail_count++;
        $error("trace or configuration not cleared by reset");
    end

    //////////////////////////////
    // APB response

    assert property (@(posedge clk) disable iff (!rst_n)
        access |-> apb_rsp.pready)
    else begin
        fail_count++;
        $error("pready low in an access cycle");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr == (access && !addr_mapped(apb_req.paddr)))
    else begin
        fail_count++;
        $error("pslverr does not follow the address map");
    end

    // Errored transfer has no side effects
    assert property (@(posedge clk) disable iff (!rst_n)
        access && apb_rsp.pslverr |-> !cfg.clear && (cfg.load == '0))
    else begin
        fail_count++;
        $error("errored transfer pulsed clear or load");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        access && apb_rsp.pslverr |=> cfg.enable == $past(cfg.enable))
    else begin
        fail_count++;
        $error("errored transfer changed the CTRL enable bit");
    end

endmodule

`default_nettype wire

/* perf_monitor_top.sv */
`timescale 1ns/100ps
`default_nettype none

module perf_monitor_top
    import perf_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input trace_events_t raw_events,
    input apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output trace_events_t tr
);

    trace_events_t captured;
    counter_cfg_t cfg;
    counter_t [num_counters-1:0] counts;
    logic [num_counters-1:0] wrap;

    //////////////////////////////
    // Trace stage
    trace_capture u_trace_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_events (raw_events),
        .captured   (captured)
    );

    assign tr = captured;

    //////////////////////////////
    // Counters and their registers
    event_counter_bank u_event_counter_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .captured (captured),
        .cfg      (cfg),
        .counts   (counts),
        .wrap     (wrap)
    );

    perf_csr_apb u_perf_csr_apb (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .counts  (counts),
        .wrap    (wrap),
        .cfg     (cfg)
    );

endmodule

`default_nettype wire

/* perf_pkg.sv */
`default_nettype none

package perf_pkg;

    //////////////////////////////
    // Sizes
    localparam int num_counters = 4;
    localparam int num_events = 19;
    localparam int counter_width = 32;

    typedef logic [counter_width-1:0] counter_t;
    typedef logic [4:0] event_sel_t;
    typedef logic [1:0] completing_t;

    //////////////////////////////
    // Event indices, in trace field order
    localparam event_sel_t ev_operand_stall = 5'd0;
    localparam event_sel_t ev_unit_stall = 5'd1;
    localparam event_sel_t ev_no_id_stall = 5'd2;
    localparam event_sel_t ev_no_instruction_stall = 5'd3;
    localparam event_sel_t ev_other_stall = 5'd4;
    localparam event_sel_t ev_instruction_issued = 5'd5;
    localparam event_sel_t ev_alu_op = 5'd6;
    localparam event_sel_t ev_branch_or_jump_op = 5'd7;
    localparam event_sel_t ev_load_op = 5'd8;
    localparam event_sel_t ev_store_op = 5'd9;
    localparam event_sel_t ev_mul_op = 5'd10;
    localparam event_sel_t ev_div_op = 5'd11;
    localparam event_sel_t ev_misc_op = 5'd12;
    localparam event_sel_t ev_branch_correct = 5'd13;
    localparam event_sel_t ev_branch_misspredict = 5'd14;
    localparam event_sel_t ev_return_correct = 5'd15;
    localparam event_sel_t ev_return_misspredict = 5'd16;
    localparam event_sel_t ev_early_branch_correction = 5'd17;
    // Multi-bit event, adds 0 to 3 per cycle
    localparam event_sel_t ev_completing = 5'd18;

    typedef struct packed {
        logic operand_stall;
        logic unit_stall;
        logic no_id_stall;
        logic no_instruction_stall;
        logic other_stall;
        logic instruction_issued;
        logic alu_op;
        logic branch_or_jump_op;
        logic load_op;
        logic store_op;
        logic mul_op;
        logic div_op;
        logic misc_op;
        logic branch_correct;
        logic branch_misspredict;
        logic return_correct;
        logic return_misspredict;
        logic early_branch_correction;
        completing_t num_instructions_completing;
    } trace_events_t;

    //////////////////////////////
    // APB
    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    // Register block to counter bank
    typedef struct packed {
        logic enable;
        logic clear;
        logic [num_counters-1:0] load;
        counter_t load_value;
        event_sel_t [num_counters-1:0] sel;
    } counter_cfg_t;

    //////////////////////////////
    // Register map
    localparam apb_addr_t addr_ctrl = 8'h00;
    localparam apb_addr_t addr_status = 8'h04;
    localparam apb_addr_t addr_sel_base = 8'h10;
    localparam apb_addr_t addr_count_base = 8'h20;
    localparam int addr_stride = 4;

    localparam int ctrl_enable_bit = 0;
    localparam int ctrl_clear_bit = 1;

endpackage

`default_nettype wire

/* tb.f */
perf_pkg.sv
trace_capture.sv
event_counter_bank.sv
perf_csr_apb.sv
perf_monitor_top.sv
perf_monitor_checker.sv
tb_clock_gen.sv
tb_perf_monitor.sv

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over the first 3 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_perf_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_perf_monitor
    import perf_pkg::*;
;

    localparam int seed = 17245;
    localparam int event_bits = $bits(trace_events_t);
    localparam int apb_max_wait = 16;
    // Budget for the watchdog, in clock cycles
    localparam int event_cycles = 200 + 60 + 60 + 40 + 3;
    localparam int settle_cycles = 3 * 6;
    localparam int apb_transfers = 40;
    localparam int transfer_cycles = 4;
    localparam int watchdog_cycles = 3 + event_cycles + settle_cycles
                                     + apb_transfers * transfer_cycles + 200;

    logic clk;
    logic rst_n;
    trace_events_t raw_events;
    trace_events_t tr;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_start_errors;

    // Reference model state
    logic model_enable;
    event_sel_t model_sel [num_counters];
    counter_t model_count [num_counters];
    logic [num_counters-1:0] model_wrap;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    perf_monitor_top u_perf_monitor_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_events (raw_events),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .tr         (tr)
    );

    bind perf_monitor_top perf_monitor_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_events (raw_events),
        .tr         (tr),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .cfg        (cfg)
    );

    function automatic int total_errors();
        return errors + u_perf_monitor_top.u_checker.fail_count;
    endfunction

    // Fields 0 to 17 sit from the top bit down, completing count in 1:0
    function automatic counter_t ref_increment(input event_sel_t sel, input trace_events_t ev);
        logic [event_bits-1:0] bits;
        bits = ev;
        if (sel < ev_completing) begin
            return counter_t'(bits[event_bits - 1 - sel]);
        end
        if (sel == ev_completing) begin
            return counter_t'(ev.num_instructions_completing);
        end
        return '0;
    endfunction

    task automatic compare_value(input string name, input apb_data_t got, input apb_data_t exp);
        checks++;
        assert (got == exp)
        else begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////
    // APB transfers
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && waited < apb_max_wait) begin
            @(negedge clk);
            waited++;
        end
        if (!apb_rsp.pready) begin
            $display("APB transfer to address 0x%02h never saw pready", addr);
            errors++;
        end
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic err;
        apb_transfer(1'b1, addr, data, rdata, err);
        compare_value("pslverr", apb_data_t'(err), 32'h0);
    endtask

    task automatic read_check(input string name, input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rdata;
        logic err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        compare_value("pslverr", apb_data_t'(err), 32'h0);
        compare_value(name, rdata, exp);
    endtask

    task automatic write_ctrl(input logic enable, input logic clear);
        write_reg(addr_ctrl, {30'b0, clear, enable});
        model_enable = enable;
        if (clear) begin
            for (int i = 0; i < num_counters; i++) begin
                model_count[i] = '0;
            end
        end
    endtask

    task automatic set_select(input int idx, input event_sel_t sel);
        write_reg(apb_addr_t'(addr_sel_base + 4 * idx), apb_data_t'(sel));
        model_sel[idx] = sel;
    endtask

    task automatic check_counts();
        for (int i = 0; i < num_counters; i++) begin
            read_check($sformatf("count[%0d]", i), apb_addr_t'(addr_count_base + 4 * i),
                       model_count[i]);
        end
    endtask

    //////////////////////////////
    // Event stimulus
    task automatic apply_event(input trace_events_t ev);
        counter_t inc;
        logic [counter_width:0] sum;
        @(posedge clk);
        raw_events <= ev;
        if (model_enable) begin
            for (int i = 0; i < num_counters; i++) begin
                inc = ref_increment(model_sel[i], ev);
                sum = {1'b0, model_count[i]} + {1'b0, inc};
                model_count[i] = sum[counter_width-1:0];
                if (sum[counter_width]) begin
                    model_wrap[i] = 1'b1;
                end
            end
        end
    endtask

    task automatic drive_random(input int cycles);
        logic [event_bits-1:0] bits;
        for (int n = 0; n < cycles; n++) begin
            bits = $urandom();
            apply_event(bits);
        end
    endtask

    // Quiet inputs until the last event has reached the counters
    task automatic settle();
        @(posedge clk);
        raw_events <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %-18s errors %0d", tests, name, total_errors() - test_start_errors);
        test_start_errors = total_errors();
    endtask

    //////////////////////////////
    // Test sequence
    initial begin
        trace_events_t ev;
        apb_data_t rdata;
        logic err;
        raw_events = '0;
        apb_req = '0;
        model_enable = 1'b0;
        model_wrap = '0;
        for (int i = 0; i < num_counters; i++) begin
            model_sel[i] = '0;
            model_count[i] = '0;
        end
        void'($urandom(seed));
        wait (rst_n === 1'b1);
        test_start_errors = total_errors();

        // 1: trace output under random events, checked by the bound checker
        drive_random(200);
        settle();
        finish_test("trace_output");

        // 2: four single-bit events
        set_select(0, ev_operand_stall);
        set_select(1, ev_alu_op);
        set_select(2, ev_branch_correct);
        set_select(3, ev_early_branch_correction);
        write_ctrl(1'b1, 1'b1);
        drive_random(60);
        settle();
        check_counts();
        finish_test("event_counting");

        // 3: completing count and an index past the last event
        set_select(0, ev_completing);
        set_select(1, 5'd25);
        write_ctrl(1'b1, 1'b1);
        drive_random(60);
        settle();
        check_counts();
        finish_test("completing_count");

        // 4: disabled counters hold, clear zeroes them
        write_ctrl(1'b0, 1'b0);
        drive_random(40);
        settle();
        check_counts();
        read_check("ctrl", addr_ctrl, 32'h0);
        write_ctrl(1'b0, 1'b1);
        check_counts();
        read_check("ctrl", addr_ctrl, 32'h0);
        finish_test("enable_clear");

        // 5: preload near the top and count across the wrap
        set_select(2, ev_alu_op);
        write_ctrl(1'b1, 1'b0);
        write_reg(apb_addr_t'(addr_count_base + 4 * 2), 32'hffff_fffe);
        model_count[2] = 32'hffff_fffe;
        ev = '0;
        ev.alu_op = 1'b1;
        for (int n = 0; n < 3; n++) begin
            apply_event(ev);
        end
        settle();
        read_check("count[2]", apb_addr_t'(addr_count_base + 4 * 2), model_count[2]);
        read_check("status", addr_status, apb_data_t'(model_wrap));
        write_reg(addr_status, 32'h4);
        model_wrap[2] = 1'b0;
        read_check("status", addr_status, apb_data_t'(model_wrap));
        finish_test("preload_wrap");

        // 6: unmapped addresses answer with an error and change nothing
        read_check("ctrl", addr_ctrl, 32'h1);
        apb_transfer(1'b1, 8'h08, 32'h0, rdata, err);
        compare_value("pslverr", apb_data_t'(err), 32'h1);
        read_check("ctrl", addr_ctrl, 32'h1);
        apb_transfer(1'b0, 8'h30, 32'h0, rdata, err);
        compare_value("pslverr", apb_data_t'(err), 32'h1);
        read_check("sel[2]", apb_addr_t'(addr_sel_base + 4 * 2), apb_data_t'(ev_alu_op));
        finish_test("apb_response");

        repeat (2) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: tests did not complete within %0d clock cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* trace_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_capture
    import perf_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input trace_events_t raw_events,
    output trace_events_t captured
);

    //////////////////////////////
    // Trace stage

    // One register stage between the pipeline and both the trace port
    // and the counters, taken every cycle regardless of counting state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            captured <= '0;
        end else begin
            captured <= raw_events;
        end
    end

endmodule

`default_nettype wire
